//--- design/sdram_pkg.sv
package sdram_pkg;

    typedef logic [21:0] user_addr_t;   // {bank, row, col}
    typedef logic [15:0] data_t;
    typedef logic [11:0] row_t;
    typedef logic [7:0]  col_t;
    typedef logic [1:0]  bank_t;

    // bit order is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LMR       = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_e;

    typedef struct packed {
        sdram_cmd_e  cmd;
        bank_t       bank;
        logic [11:0] addr;
        logic        dqm;
        logic        dq_oe;
        data_t       wdata;
    } sdram_pin_s;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_REFRESH,
        ST_READ,
        ST_WRITE
    } ctrl_state_e;

    localparam sdram_pin_s PIN_NOP = '{
        cmd:   CMD_NOP,
        bank:  '0,
        addr:  '0,
        dqm:   1'b1,
        dq_oe: 1'b0,
        wdata: '0
    };

    function automatic bank_t addr_bank(user_addr_t a);
        return a[21:20];
    endfunction

    function automatic row_t addr_row(user_addr_t a);
        return a[19:8];
    endfunction

    function automatic col_t addr_col(user_addr_t a);
        return a[7:0];
    endfunction

endpackage

//--- design/sdram_refresh_timer.sv
`timescale 1ns/10ps

module sdram_refresh_timer #(
    parameter int REFRESH_PERIOD = 1262
) (
    input  logic clk,
    input  logic rst_n,
    input  logic init_done,
    input  logic ref_ack,
    output logic ref_req
);

    localparam int CNT_W = $clog2(REFRESH_PERIOD + 1);

    logic [CNT_W-1:0] cnt;
    logic             end_cnt;

    assign end_cnt = init_done && (cnt == CNT_W'(REFRESH_PERIOD - 1));

    // free running once the device is up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (end_cnt) begin
            cnt <= '0;
        end else if (init_done) begin
            cnt <= cnt + 1'b1;
        end
    end

    // a new period wins over a late ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_req <= 1'b0;
        end else if (end_cnt) begin
            ref_req <= 1'b1;
        end else if (ref_ack) begin
            ref_req <= 1'b0;
        end
    end

endmodule

//--- design/sdram_ctrl_fsm.sv
`timescale 1ns/10ps

module sdram_ctrl_fsm #(
    parameter int T_INIT    = 20000,
    parameter int T_RP      = 2,
    parameter int T_RC      = 7,
    parameter int T_MRD     = 2,
    parameter int T_RCD     = 2,
    parameter int CAS_LAT   = 3,
    parameter int BURST_LEN = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_req,
    input  logic                  rd_req,
    input  sdram_pkg::user_addr_t waddr,
    input  sdram_pkg::user_addr_t raddr,
    input  sdram_pkg::data_t      wdata,
    output logic                  wr_ack,
    output logic                  rd_ack,
    input  logic                  ref_req,
    output logic                  ref_ack,
    output logic                  init_done,
    output sdram_pkg::sdram_pin_s pin_req
);
    import sdram_pkg::*;

    localparam int RW_MAX  = BURST_LEN + CAS_LAT + T_RCD + T_RP + T_RC + T_MRD;
    localparam int LEN_MAX = (T_INIT > RW_MAX) ? T_INIT : RW_MAX;
    localparam int SUB_W   = $clog2(LEN_MAX + 1);
    localparam int PH_W    = 4;

    // init phases: wait, precharge, 8 x refresh, lmr
    localparam logic [PH_W-1:0] PH_INIT_WAIT = 4'd0;
    localparam logic [PH_W-1:0] PH_INIT_PRE  = 4'd1;
    localparam logic [PH_W-1:0] PH_INIT_LMR  = 4'd10;
    // read / write phases
    localparam logic [PH_W-1:0] PH_ACT = 4'd0;
    localparam logic [PH_W-1:0] PH_RW  = 4'd1;

    // no write burst override, sequential, programmed CL and BL
    localparam logic [11:0] MODE_REG = {2'b00, 1'b0, 2'b00, 3'(CAS_LAT), 1'b0,
                                        3'($clog2(BURST_LEN))};

    ctrl_state_e      state;
    ctrl_state_e      state_n;
    logic [SUB_W-1:0] sub;
    logic [PH_W-1:0]  phase;
    logic             busy;
    logic             first;
    logic             end_sub;
    logic             end_phase;
    logic             pick_rd;
    logic             pick_wr;
    logic             last_wr;
    logic             rd_dqm_win;
    user_addr_t       op_addr;

    function automatic int phase_len(ctrl_state_e st, logic [PH_W-1:0] ph);
        int len;
        len = 1;
        case (st)
            ST_INIT: begin
                if (ph == PH_INIT_WAIT) len = T_INIT;
                else if (ph == PH_INIT_PRE) len = T_RP;
                else if (ph == PH_INIT_LMR) len = T_MRD;
                else len = T_RC;
            end
            ST_REFRESH: len = T_RC;
            ST_READ, ST_WRITE: begin
                if (ph == PH_ACT) len = T_RCD;
                else if (ph == PH_RW) len = (st == ST_READ) ? BURST_LEN + CAS_LAT : BURST_LEN;
                else len = T_RP;
            end
            default: len = 1;
        endcase
        return len;
    endfunction

    function automatic logic [PH_W-1:0] last_phase(ctrl_state_e st);
        case (st)
            ST_INIT:           return PH_INIT_LMR;
            ST_READ, ST_WRITE: return 4'd2;
            default:           return 4'd0;
        endcase
    endfunction

    assign busy      = state != ST_IDLE;
    assign first     = busy && sub == '0;
    assign end_sub   = busy && int'(sub) == phase_len(state, phase) - 1;
    assign end_phase = end_sub && phase == last_phase(state);

    // both pending: opposite of the last one served
    assign pick_rd = rd_req && (!wr_req || last_wr);
    assign pick_wr = wr_req && !pick_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sub   <= '0;
            phase <= '0;
        end else if (end_sub) begin
            sub   <= '0;
            phase <= end_phase ? '0 : phase + 1'b1;
        end else if (busy) begin
            sub <= sub + 1'b1;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            ST_IDLE: begin
                if (ref_req) state_n = ST_REFRESH;
                else if (pick_rd) state_n = ST_READ;
                else if (pick_wr) state_n = ST_WRITE;
            end
            ST_INIT, ST_REFRESH, ST_READ, ST_WRITE: begin
                if (end_phase) state_n = ST_IDLE;
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_INIT;
            init_done <= 1'b0;
            last_wr   <= 1'b1;   // first contested grant goes to read
            rd_ack    <= 1'b0;
        end else begin
            state  <= state_n;
            rd_ack <= state == ST_READ && phase == PH_RW && first; // lines up with READ on pins
            if (state == ST_INIT && end_phase) init_done <= 1'b1;
            if (state_n == ST_READ && state == ST_IDLE) last_wr <= 1'b0;
            if (state_n == ST_WRITE && state == ST_IDLE) last_wr <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && !ref_req) begin
            if (pick_rd) op_addr <= raddr;
            else if (pick_wr) op_addr <= waddr;
        end
    end

    assign ref_ack = state == ST_REFRESH && first;
    assign wr_ack  = state == ST_WRITE && phase == PH_RW;   // one per beat

    // dqm read latency is two cycles
    assign rd_dqm_win = int'(sub) >= CAS_LAT - 2 && int'(sub) < CAS_LAT - 2 + BURST_LEN;

    always_comb begin
        pin_req = PIN_NOP;
        case (state)
            ST_INIT: begin
                if (first && phase == PH_INIT_PRE) begin
                    pin_req.cmd      = CMD_PRECHARGE;
                    pin_req.addr[10] = 1'b1;
                end else if (first && phase == PH_INIT_LMR) begin
                    pin_req.cmd  = CMD_LMR;
                    pin_req.addr = MODE_REG;
                end else if (first && phase != PH_INIT_WAIT) begin
                    pin_req.cmd = CMD_REFRESH;
                end
            end
            ST_REFRESH: begin
                if (first) pin_req.cmd = CMD_REFRESH;
            end
            ST_READ, ST_WRITE: begin
                if (first) begin
                    case (phase)
                        PH_ACT: begin
                            pin_req.cmd  = CMD_ACTIVE;
                            pin_req.bank = addr_bank(op_addr);
                            pin_req.addr = addr_row(op_addr);
                        end
                        PH_RW: begin
                            pin_req.cmd  = (state == ST_WRITE) ? CMD_WRITE : CMD_READ;
                            pin_req.bank = addr_bank(op_addr);
                            pin_req.addr = {4'b0000, addr_col(op_addr)}; // a10 low, no auto precharge
                        end
                        default: begin
                            pin_req.cmd      = CMD_PRECHARGE;
                            pin_req.addr[10] = 1'b1;
                        end
                    endcase
                end
                if (phase == PH_RW) begin
                    if (state == ST_WRITE) begin
                        pin_req.dq_oe = 1'b1;
                        pin_req.dqm   = 1'b0;
                        pin_req.wdata = wdata;
                    end else if (rd_dqm_win) begin
                        pin_req.dqm = 1'b0;
                    end
                end
            end
            default: pin_req = PIN_NOP;
        endcase
    end

endmodule

//--- design/sdram_io.sv
`timescale 1ns/10ps

module sdram_io #(
    parameter int CAS_LAT   = 3,
    parameter int BURST_LEN = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sdram_pkg::sdram_pin_s pin_req,
    output logic                  cke,
    output logic                  cs_n,
    output logic                  ras_n,
    output logic                  cas_n,
    output logic                  we_n,
    output logic                  dqm,
    output logic [11:0]           addr,
    output sdram_pkg::bank_t      bank,
    inout  wire sdram_pkg::data_t dq,
    output sdram_pkg::data_t      rdata,
    output logic                  rdata_vld
);
    import sdram_pkg::*;

    localparam int CNT_W = $clog2(BURST_LEN + 1);
    localparam int DLY   = CAS_LAT - 1;

    sdram_pin_s       pin_q;
    logic [CNT_W-1:0] win_cnt;
    logic             win;
    logic [DLY-1:0]   win_dly;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pin_q <= PIN_NOP;
        else pin_q <= pin_req;
    end

    assign cke = 1'b1;
    assign {cs_n, ras_n, cas_n, we_n} = pin_q.cmd;
    assign dqm  = pin_q.dqm;
    assign addr = pin_q.addr;
    assign bank = pin_q.bank;
    assign dq   = pin_q.dq_oe ? pin_q.wdata : 'z;

    // burst window opens the cycle after READ is on the pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= '0;
        end else if (pin_q.cmd == CMD_READ) begin
            win_cnt <= CNT_W'(BURST_LEN);
        end else if (win) begin
            win_cnt <= win_cnt - 1'b1;
        end
    end

    assign win = win_cnt != '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_dly   <= '0;
            rdata_vld <= 1'b0;
        end else begin
            win_dly   <= DLY'({win_dly, win});
            rdata_vld <= win_dly[DLY-1];   // cas latency edges after the READ sample
        end
    end

    always_ff @(posedge clk) begin
        if (win_dly[DLY-1]) rdata <= dq;
    end

endmodule

//--- design/sdram_top.sv
`timescale 1ns/10ps

module sdram_top #(
    parameter int T_INIT         = 20000,
    parameter int T_RP           = 2,
    parameter int T_RC           = 7,
    parameter int T_MRD          = 2,
    parameter int T_RCD          = 2,
    parameter int CAS_LAT        = 3,
    parameter int BURST_LEN      = 4,
    parameter int REFRESH_PERIOD = 1262
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_req,
    input  sdram_pkg::user_addr_t waddr,
    input  sdram_pkg::data_t      wdata,
    output logic                  wr_ack,
    input  logic                  rd_req,
    input  sdram_pkg::user_addr_t raddr,
    output logic                  rd_ack,
    output sdram_pkg::data_t      rdata,
    output logic                  rdata_vld,
    output logic                  init_done,
    output logic                  cke,
    output logic                  cs_n,
    output logic                  ras_n,
    output logic                  cas_n,
    output logic                  we_n,
    output logic                  dqm,
    output logic [11:0]           addr,
    output sdram_pkg::bank_t      bank,
    inout  wire sdram_pkg::data_t dq
);
    import sdram_pkg::*;

    logic       ref_req;
    logic       ref_ack;
    sdram_pin_s pin_req;

    sdram_refresh_timer #(
        .REFRESH_PERIOD(REFRESH_PERIOD)
    ) u_refresh_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .init_done(init_done),
        .ref_ack  (ref_ack),
        .ref_req  (ref_req)
    );

    sdram_ctrl_fsm #(
        .T_INIT   (T_INIT),
        .T_RP     (T_RP),
        .T_RC     (T_RC),
        .T_MRD    (T_MRD),
        .T_RCD    (T_RCD),
        .CAS_LAT  (CAS_LAT),
        .BURST_LEN(BURST_LEN)
    ) u_ctrl_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .waddr    (waddr),
        .raddr    (raddr),
        .wdata    (wdata),
        .wr_ack   (wr_ack),
        .rd_ack   (rd_ack),
        .ref_req  (ref_req),
        .ref_ack  (ref_ack),
        .init_done(init_done),
        .pin_req  (pin_req)
    );

    sdram_io #(
        .CAS_LAT  (CAS_LAT),
        .BURST_LEN(BURST_LEN)
    ) u_io (
        .clk      (clk),
        .rst_n    (rst_n),
        .pin_req  (pin_req),
        .cke      (cke),
        .cs_n     (cs_n),
        .ras_n    (ras_n),
        .cas_n    (cas_n),
        .we_n     (we_n),
        .dqm      (dqm),
        .addr     (addr),
        .bank     (bank),
        .dq       (dq),
        .rdata    (rdata),
        .rdata_vld(rdata_vld)
    );

endmodule

//--- testbench/sdram_model.sv
`timescale 1ns/10ps

module sdram_model #(
    parameter int CAS_LAT   = 3,
    parameter int BURST_LEN = 4
) (
    input  logic                  clk,
    input  logic                  cke,
    input  logic                  cs_n,
    input  logic                  ras_n,
    input  logic                  cas_n,
    input  logic                  we_n,
    input  logic                  dqm,
    input  logic [11:0]           addr,
    input  sdram_pkg::bank_t      bank,
    inout  wire sdram_pkg::data_t dq
);
    import sdram_pkg::*;

    data_t      mem [user_addr_t];
    row_t       open_row [4];
    logic [3:0] cmd;
    user_addr_t rd_base;
    user_addr_t wr_base;
    int         rd_wait;
    int         rd_left = 0;
    int         rd_k;
    int         wr_left = 0;
    int         wr_k;
    data_t      drv_data;
    logic       drv_en = 1'b0;
    logic       dqm_q = 1'b1;   // dqm from the previous edge

    assign cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq  = drv_en ? drv_data : 'z;

    // sequential burst inside the aligned block
    function automatic user_addr_t wrap(user_addr_t base, int k);
        col_t c;
        c = base[7:0];
        c = (c & ~col_t'(BURST_LEN - 1)) | ((c + col_t'(k)) & col_t'(BURST_LEN - 1));
        return {base[21:8], c};
    endfunction

    always @(posedge clk) begin
        if (cke) begin
            if (cmd == CMD_ACTIVE) open_row[bank] = addr;

            if (cmd == CMD_WRITE) begin
                wr_base = {bank, open_row[bank], addr[7:0]};
                if (!dqm) mem[wrap(wr_base, 0)] = dq;
                wr_k    = 1;
                wr_left = BURST_LEN - 1;
            end else if (wr_left > 0) begin
                if (!dqm) mem[wrap(wr_base, wr_k)] = dq;
                wr_k++;
                wr_left--;
            end

            if (cmd == CMD_READ) begin
                rd_base = {bank, open_row[bank], addr[7:0]};
                rd_wait = CAS_LAT - 2;   // first beat lands CAS_LAT edges after READ
                rd_left = BURST_LEN;
                rd_k    = 0;
            end else if (rd_left > 0) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else begin
                    drv_data <= mem[wrap(rd_base, rd_k)];
                    drv_en   <= !dqm_q;   // dqm read latency of two
                    rd_k++;
                    rd_left--;
                end
            end else begin
                drv_en <= 1'b0;
            end

            dqm_q = dqm;
        end
    end

endmodule

//--- testbench/sdram_props.sv
`timescale 1ns/10ps

module sdram_props #(
    parameter int T_RCD     = 2,
    parameter int CAS_LAT   = 3,
    parameter int BURST_LEN = 4
) (
    input logic clk,
    input logic rst_n,
    input logic wr_ack,
    input logic rd_ack,
    input logic rdata_vld,
    input logic init_done,
    input logic cs_n,
    input logic ras_n,
    input logic cas_n,
    input logic we_n
);
    import sdram_pkg::*;

    logic [3:0] cmd;
    int         owed;        // read beats still to come
    int         since_act;

    assign cmd = {cs_n, ras_n, cas_n, we_n};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owed      <= 0;
            since_act <= 0;
        end else begin
            owed <= owed + (rd_ack ? BURST_LEN : 0) - (rdata_vld ? 1 : 0);
            if (cmd == CMD_ACTIVE) since_act <= 1;
            else if (since_act < 1000) since_act <= since_act + 1;
        end
    end

    ack_excl: assert property (@(posedge clk) disable iff (!rst_n) !(wr_ack && rd_ack))
        else $error("wr_ack and rd_ack high together");

    rd_first_beat: assert property (@(posedge clk) disable iff (!rst_n)
        rd_ack |-> ##(CAS_LAT + 1) rdata_vld)
        else $error("first read beat late");

    rd_beat_count: assert property (@(posedge clk) disable iff (!rst_n)
        rd_ack |-> ##(CAS_LAT + BURST_LEN + 1) owed == 0)
        else $error("wrong number of read beats");

    rd_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_vld |-> owed > 0)
        else $error("read beat without a request");

    rcd_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> since_act >= T_RCD)
        else $error("column command too soon after ACTIVE");

    init_cmds: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> (cmd == CMD_NOP || cmd == CMD_PRECHARGE || cmd == CMD_REFRESH ||
                        cmd == CMD_LMR))
        else $error("user command before init done");

endmodule

bind sdram_top sdram_props #(
    .T_RCD    (T_RCD),
    .CAS_LAT  (CAS_LAT),
    .BURST_LEN(BURST_LEN)
) u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_ack   (wr_ack),
    .rd_ack   (rd_ack),
    .rdata_vld(rdata_vld),
    .init_done(init_done),
    .cs_n     (cs_n),
    .ras_n    (ras_n),
    .cas_n    (cas_n),
    .we_n     (we_n)
);

//--- testbench/sdram_tb.sv
`timescale 1ns/10ps

module sdram_tb;
    import sdram_pkg::*;

    localparam int T_INIT         = 200;
    localparam int T_RP           = 2;
    localparam int T_RC           = 7;
    localparam int T_MRD          = 2;
    localparam int T_RCD          = 2;
    localparam int CAS_LAT        = 3;
    localparam int BURST_LEN      = 4;
    localparam int REFRESH_PERIOD = 300;
    localparam int INIT_CYC       = T_INIT + T_RP + 8 * T_RC + T_MRD;
    localparam int OP_MAX         = 2 * (T_RCD + BURST_LEN + CAS_LAT + T_RP + 2) + T_RC + 8;
    localparam int NUM            = 14;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_BOTH, OP_WAIT} op_e;

    typedef struct packed {
        op_e        op;
        user_addr_t addr;
        logic       use_lfsr;
        data_t      data;      // base word, or idle cycles for OP_WAIT
    } stim_s;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       wr_req;
    logic       rd_req;
    user_addr_t waddr;
    user_addr_t raddr;
    data_t      wdata;
    logic       wr_ack;
    logic       rd_ack;
    data_t      rdata;
    logic       rdata_vld;
    logic       init_done;
    logic       cke;
    logic       cs_n;
    logic       ras_n;
    logic       cas_n;
    logic       we_n;
    logic       dqm;
    logic [11:0] addr;
    bank_t      bank;
    wire data_t dq;

    stim_s      tbl [NUM];
    data_t      ref_mem [user_addr_t];
    data_t      rq [$];
    data_t      wbeat [BURST_LEN];
    data_t      exp_beat [BURST_LEN];
    logic [31:0] lfsr = 32'h5a62_1669;
    logic       last_wr = 1'b1;   // first contested grant goes to read
    logic       early_ack = 1'b0;
    int         ref_cnt = 0;
    int         err_cnt = 0;
    int         cyc;

    sdram_top #(
        .T_INIT(T_INIT), .T_RP(T_RP), .T_RC(T_RC), .T_MRD(T_MRD), .T_RCD(T_RCD),
        .CAS_LAT(CAS_LAT), .BURST_LEN(BURST_LEN), .REFRESH_PERIOD(REFRESH_PERIOD)
    ) dut (.*);

    sdram_model #(.CAS_LAT(CAS_LAT), .BURST_LEN(BURST_LEN)) u_model (
        .clk(clk), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n),
        .dqm(dqm), .addr(addr), .bank(bank), .dq(dq)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && !init_done && (wr_ack || rd_ack || rdata_vld)) early_ack = 1'b1;
        if (init_done && {cs_n, ras_n, cas_n, we_n} == CMD_REFRESH) ref_cnt++;
        if (rdata_vld) rq.push_back(rdata);
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic draw_word(output data_t w);
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hA300_0000 : lfsr >> 1;   // galois step
            w[b] = lfsr[0];
        end
    endtask

    function automatic user_addr_t beat_addr(user_addr_t a, int k);
        col_t c;
        c = a[7:0];
        c = (c & ~col_t'(BURST_LEN - 1)) | ((c + col_t'(k)) & col_t'(BURST_LEN - 1));
        return {a[21:8], c};
    endfunction

    task automatic store_burst(input user_addr_t a);
        for (int k = 0; k < BURST_LEN; k++) ref_mem[beat_addr(a, k)] = wbeat[k];
    endtask

    function automatic void load_table();
        tbl[0]  = '{OP_WR,   {2'd0, 12'h001, 8'h10}, 1'b0, 16'h1000};
        tbl[1]  = '{OP_RD,   {2'd0, 12'h001, 8'h10}, 1'b0, 16'h0000};
        tbl[2]  = '{OP_WR,   {2'd1, 12'h0a5, 8'h22}, 1'b1, 16'h0000};  // wraps
        tbl[3]  = '{OP_RD,   {2'd1, 12'h0a5, 8'h20}, 1'b0, 16'h0000};
        tbl[4]  = '{OP_RD,   {2'd1, 12'h0a5, 8'h23}, 1'b0, 16'h0000};
        tbl[5]  = '{OP_WR,   {2'd3, 12'hfff, 8'hfc}, 1'b0, 16'hbee0};
        tbl[6]  = '{OP_BOTH, {2'd0, 12'h001, 8'h10}, 1'b1, 16'h0000};
        tbl[7]  = '{OP_RD,   {2'd0, 12'h001, 8'h10}, 1'b0, 16'h0000};
        tbl[8]  = '{OP_WAIT, 22'h0,                  1'b0, 16'd700};
        tbl[9]  = '{OP_WR,   {2'd2, 12'h3c3, 8'h81}, 1'b1, 16'h0000};
        tbl[10] = '{OP_WAIT, 22'h0,                  1'b0, 16'd400};
        tbl[11] = '{OP_RD,   {2'd2, 12'h3c3, 8'h81}, 1'b0, 16'h0000};
        tbl[12] = '{OP_RD,   {2'd3, 12'hfff, 8'hfc}, 1'b0, 16'h0000};
        tbl[13] = '{OP_BOTH, {2'd3, 12'hfff, 8'hfe}, 1'b1, 16'h0000};  // write first after reads
    endfunction

    task automatic run_entry(input int i);
        stim_s e;
        string name;
        logic  do_wr;
        logic  do_rd;
        logic  pred_rd_first;
        logic  rd_first;
        logic  seen;
        logic  wr_done;
        logic  rd_done;
        int    cnt;
        e    = tbl[i];
        name = $sformatf("entry%0d", i);
        if (e.op == OP_WAIT) begin
            repeat (int'(e.data)) @(negedge clk);
            return;
        end
        do_wr = e.op == OP_WR || e.op == OP_BOTH;
        do_rd = e.op == OP_RD || e.op == OP_BOTH;
        pred_rd_first = do_rd && (!do_wr || last_wr);
        if (do_wr) begin
            for (int k = 0; k < BURST_LEN; k++) begin
                if (e.use_lfsr) draw_word(wbeat[k]);
                else wbeat[k] = e.data + data_t'(k);
            end
        end
        if (do_wr && !pred_rd_first) store_burst(e.addr);
        if (do_rd) begin
            for (int k = 0; k < BURST_LEN; k++) exp_beat[k] = ref_mem[beat_addr(e.addr, k)];
        end
        if (do_wr && pred_rd_first) store_burst(e.addr);

        rq.delete();
        wr_done  = !do_wr;
        rd_done  = !do_rd;
        seen     = 1'b0;
        rd_first = 1'b0;
        cnt      = 0;
        wr_req   = do_wr;
        rd_req   = do_rd;
        waddr    = do_wr ? e.addr : ~e.addr;   // idle port points elsewhere
        raddr    = do_rd ? e.addr : ~e.addr;
        wdata    = wbeat[0];
        while (!(wr_done && rd_done)) begin
            if (rd_ack && !rd_done) begin
                rd_done = 1'b1;
                if (!seen) rd_first = 1'b1;
                seen = 1'b1;
            end
            if (wr_ack && !wr_done) begin   // the coming edge takes wbeat[cnt]
                seen = 1'b1;
                cnt++;
                if (cnt == BURST_LEN) wr_done = 1'b1;
            end
            @(negedge clk);
            if (rd_done) rd_req = 1'b0;
            if (wr_done) wr_req = 1'b0;
            else wdata = wbeat[cnt];
        end

        if (do_wr && do_rd) check({name, " order"}, pred_rd_first, rd_first);
        if (do_rd) begin
            while (rq.size() < BURST_LEN) @(negedge clk);
            for (int k = 0; k < BURST_LEN; k++) check(name, exp_beat[k], rq[k]);
        end
        last_wr = do_wr && (!do_rd || pred_rd_first);
    endtask

    initial begin
        rst_n  = 1'b0;
        wr_req = 1'b0;
        rd_req = 1'b0;
        waddr  = '0;
        raddr  = '0;
        wdata  = '0;
        load_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        cyc   = 0;
        do begin
            @(posedge clk);
            cyc++;
            @(negedge clk);
        end while (!init_done);
        check("init_time", INIT_CYC, cyc);
        check("early_ack", 0, early_ack);
        for (int i = 0; i < NUM; i++) run_entry(i);
        check("refresh_seen", 1, ref_cnt != 0);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "errors seen");
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = 16 + INIT_CYC;
        foreach (tbl[i]) begin
            limit += OP_MAX + REFRESH_PERIOD;
            if (tbl[i].op == OP_WAIT) limit += int'(tbl[i].data);
        end
        limit *= 2;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sim.f
design/sdram_pkg.sv
design/sdram_refresh_timer.sv
design/sdram_ctrl_fsm.sv
design/sdram_io.sv
design/sdram_top.sv
testbench/sdram_model.sv
testbench/sdram_props.sv
testbench/sdram_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module sdram_tb -Mdir obj_dir -o sdram_sim -f sim.f

./obj_dir/sdram_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1
